// ==== cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int MEM_DEPTH = 256;
    localparam int REG_COUNT = 8;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  mem_addr_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_LDI   = 4'h5,
        OP_LDH   = 4'h6,
        OP_CMPEQ = 4'h7,
        OP_CMPLT = 4'h8,
        OP_BRF   = 4'h9,
        OP_LD    = 4'ha,
        OP_ST    = 4'hb,
        OP_HALT  = 4'hc
    } opcode_e;

    // For CMP, rd selects the flag. For BRF, ra selects the flag.
    typedef struct packed {
        opcode_e    opcode;
        reg_idx_t   rd;
        reg_idx_t   ra;
        reg_idx_t   rb;
        logic [2:0] spare;
        imm_t       imm;
    } instr_t;

    // Held by the requester until granted.
    typedef struct packed {
        logic      valid;
        logic      write;
        mem_addr_t addr;
        word_t     wdata;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXECUTE,
        MEM_WAIT,
        HALTED
    } core_state_e;

endpackage

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire cpu_pkg::opcode_e op,
    input  wire cpu_pkg::word_t   a,
    input  wire cpu_pkg::word_t   b,
    input  wire cpu_pkg::imm_t    imm,
    output cpu_pkg::word_t        result,
    output logic                  cmp
);
    import cpu_pkg::*;

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_LDI: begin
                result = {16'h0000, imm};
            end
            // Upper half from the immediate, lower half kept.
            OP_LDH: begin
                result = {imm, a[15:0]};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    always_comb begin
        case (op)
            OP_CMPEQ: begin
                cmp = (a == b);
            end
            OP_CMPLT: begin
                cmp = (a < b);  // unsigned
            end
            default: begin
                cmp = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire cpu_pkg::reg_idx_t ra,
    input  wire cpu_pkg::reg_idx_t rb,
    output cpu_pkg::word_t         a,
    output cpu_pkg::word_t         b,
    input  wire                    we,
    input  wire cpu_pkg::reg_idx_t wd_idx,
    input  wire cpu_pkg::word_t    wd,
    input  wire cpu_pkg::reg_idx_t flag_idx,
    output logic                   flag_out,
    input  wire                    flag_we,
    input  wire cpu_pkg::reg_idx_t flag_wr_idx,
    input  wire                    flag_in
);
    import cpu_pkg::*;

    word_t                regs [REG_COUNT];
    logic [REG_COUNT-1:0] flags;

    assign a        = regs[ra];
    assign b        = regs[rb];
    assign flag_out = flags[flag_idx];

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
            flags <= '0;
        end else begin
            if (we) begin
                regs[wd_idx] <= wd;
            end
            if (flag_we) begin
                flags[flag_wr_idx] <= flag_in;
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_core (
    input  wire                 clock,
    input  wire                 rst_n,
    input  wire                 start,
    output cpu_pkg::mem_req_t   core_req,
    input  wire                 core_gnt,
    input  wire                 core_rvalid,
    input  wire cpu_pkg::word_t rdata,
    output logic                halted
);
    import cpu_pkg::*;

    core_state_e state;
    mem_addr_t   pc;
    mem_addr_t   pc_next;
    instr_t      instr;
    logic        data_phase;

    reg_idx_t    rf_ra;
    word_t       op_a;
    word_t       op_b;
    word_t       alu_result;
    logic        alu_cmp;
    logic        flag_val;
    logic        fetch_done;
    logic        load_done;
    logic        reg_we;
    logic        flag_we;
    word_t       reg_wd;

    function automatic mem_req_t fetch_req(mem_addr_t addr);
        return '{valid: 1'b1, write: 1'b0, addr: addr, wdata: '0};
    endfunction

    // LDH merges into rd, so rd is read through port a.
    assign rf_ra = (instr.opcode == OP_LDH) ? instr.rd : instr.ra;

    assign fetch_done = (state == MEM_WAIT) && !data_phase && core_rvalid;
    assign load_done  = (state == MEM_WAIT) && data_phase && !core_req.valid && core_rvalid;
    assign reg_wd     = load_done ? rdata : alu_result;
    assign pc_next    = (instr.opcode == OP_BRF && flag_val) ? instr.imm[7:0] : pc + 8'd1;
    assign halted     = (state == HALTED);

    always_comb begin
        reg_we  = load_done;
        flag_we = 1'b0;
        if (state == EXECUTE) begin
            case (instr.opcode)
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LDI, OP_LDH: begin
                    reg_we = 1'b1;
                end
                OP_CMPEQ, OP_CMPLT: begin
                    flag_we = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    alu i_alu (
        .op     (instr.opcode),
        .a      (op_a),
        .b      (op_b),
        .imm    (instr.imm),
        .result (alu_result),
        .cmp    (alu_cmp)
    );

    reg_file i_reg_file (
        .clock       (clock),
        .rst_n       (rst_n),
        .ra          (rf_ra),
        .rb          (instr.rb),
        .a           (op_a),
        .b           (op_b),
        .we          (reg_we),
        .wd_idx      (instr.rd),
        .wd          (reg_wd),
        .flag_idx    (instr.ra),
        .flag_out    (flag_val),
        .flag_we     (flag_we),
        .flag_wr_idx (instr.rd),
        .flag_in     (alu_cmp)
    );

    always_ff @(posedge clock) begin
        if (fetch_done) begin
            instr <= instr_t'(rdata);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            state      <= IDLE;
            pc         <= '0;
            data_phase <= 1'b0;
            core_req   <= '0;
        end else begin
            case (state)
                IDLE, HALTED: begin
                    if (start) begin
                        pc       <= '0;
                        core_req <= fetch_req('0);
                        state    <= FETCH;
                    end
                end
                FETCH: begin
                    if (core_gnt) begin
                        core_req.valid <= 1'b0;
                        data_phase     <= 1'b0;
                        state          <= MEM_WAIT;
                    end
                end
                EXECUTE: begin
                    pc <= pc_next;
                    case (instr.opcode)
                        OP_HALT: begin
                            state <= HALTED;
                        end
                        OP_LD, OP_ST: begin
                            core_req   <= '{valid: 1'b1, write: (instr.opcode == OP_ST),
                                            addr: op_a[7:0], wdata: op_b};
                            data_phase <= 1'b1;
                            state      <= MEM_WAIT;
                        end
                        default: begin
                            core_req <= fetch_req(pc_next);
                            state    <= FETCH;
                        end
                    endcase
                end
                MEM_WAIT: begin
                    if (core_req.valid) begin
                        // A store is done once the memory accepts it.
                        if (core_gnt && core_req.write) begin
                            core_req <= fetch_req(pc);
                            state    <= FETCH;
                        end else if (core_gnt) begin
                            core_req.valid <= 1'b0;
                        end
                    end else if (load_done) begin
                        core_req <= fetch_req(pc);
                        state    <= FETCH;
                    end else if (fetch_done) begin
                        state <= EXECUTE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mem_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire cpu_pkg::mem_req_t host_req,
    output logic                   host_gnt,
    output logic                   host_rvalid,
    input  wire cpu_pkg::mem_req_t core_req,
    output logic                   core_gnt,
    output logic                   core_rvalid,
    output cpu_pkg::mem_req_t      mem_cmd
);

    logic rd_pending;
    logic rd_host;

    // Host always wins, the core waits while the host holds valid.
    assign host_gnt = host_req.valid;
    assign core_gnt = core_req.valid && !host_req.valid;
    assign mem_cmd  = host_req.valid ? host_req : core_req;

    assign host_rvalid = rd_pending && rd_host;
    assign core_rvalid = rd_pending && !rd_host;

    // Read data lags acceptance by one cycle, so remember who asked.
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rd_pending <= 1'b0;
            rd_host    <= 1'b0;
        end else begin
            rd_pending <= mem_cmd.valid && !mem_cmd.write;
            if (mem_cmd.valid) begin
                rd_host <= host_gnt;
            end
        end
    end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/1ns
`default_nettype none

module data_mem (
    input  wire                    clock,
    input  wire cpu_pkg::mem_req_t mem_cmd,
    output cpu_pkg::word_t         mem_rdata
);
    import cpu_pkg::*;

    word_t ram [MEM_DEPTH];

    // Registered read, write lands on the accepting edge.
    always_ff @(posedge clock) begin
        if (mem_cmd.valid) begin
            if (mem_cmd.write) begin
                ram[mem_cmd.addr] <= mem_cmd.wdata;
            end else begin
                mem_rdata <= ram[mem_cmd.addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  wire                    clock,
    input  wire                    rst_n,
    input  wire cpu_pkg::mem_req_t host_req,
    output logic                   host_gnt,
    input  wire                    start,
    output cpu_pkg::word_t         rdata,
    output logic                   rvalid,
    output logic                   halted
);
    import cpu_pkg::*;

    mem_req_t core_req;
    mem_req_t mem_cmd;
    word_t    mem_rdata;
    logic     core_gnt;
    logic     core_rvalid;

    assign rdata = mem_rdata;

    cpu_core i_cpu_core (
        .clock       (clock),
        .rst_n       (rst_n),
        .start       (start),
        .core_req    (core_req),
        .core_gnt    (core_gnt),
        .core_rvalid (core_rvalid),
        .rdata       (mem_rdata),
        .halted      (halted)
    );

    mem_arbiter i_mem_arbiter (
        .clock       (clock),
        .rst_n       (rst_n),
        .host_req    (host_req),
        .host_gnt    (host_gnt),
        .host_rvalid (rvalid),
        .core_req    (core_req),
        .core_gnt    (core_gnt),
        .core_rvalid (core_rvalid),
        .mem_cmd     (mem_cmd)
    );

    data_mem i_data_mem (
        .clock     (clock),
        .mem_cmd   (mem_cmd),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== cpu_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_chk (
    input wire                    clock,
    input wire                    rst_n,
    input wire                    host_gnt,
    input wire                    core_gnt,
    input wire cpu_pkg::mem_req_t core_req,
    input wire                    halted
);

    a_one_grant: assert property (@(posedge clock) disable iff (!rst_n)
        !(host_gnt && core_gnt))
        else $error("host and core granted in the same cycle");

    // A waiting core request keeps address, data and direction.
    a_req_held: assert property (@(posedge clock) disable iff (!rst_n)
        (core_req.valid && !core_gnt) |=> $stable(core_req))
        else $error("core request changed while waiting for grant");

    a_reset_halted: assert property (@(posedge clock) !rst_n |=> !halted)
        else $error("halted high after reset");

endmodule

bind mem_arbiter cpu_chk i_chk_arbiter (
    .clock    (clock),
    .rst_n    (rst_n),
    .host_gnt (host_gnt),
    .core_gnt (core_gnt),
    .core_req (core_req),
    .halted   (1'b0)
);

bind cpu_core cpu_chk i_chk_core (
    .clock    (clock),
    .rst_n    (rst_n),
    .host_gnt (1'b0),
    .core_gnt (core_gnt),
    .core_req (core_req),
    .halted   (halted)
);

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Reset is held low for the first four rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_monitor.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_monitor (
    input  wire                    clock,
    input  wire cpu_pkg::mem_req_t host_req,
    input  wire                    host_gnt,
    input  wire                    rvalid,
    input  wire cpu_pkg::word_t    rdata,
    input  wire                    halted,
    input  wire                    armed,
    input  wire cpu_pkg::word_t    exp_data,
    input  wire                    test_done,
    input  int                     test_idx,
    output int                     pass_count,
    output int                     fail_count
);

    int   errors;
    int   reads;
    logic read_due;

    initial begin
        pass_count = 0;
        fail_count = 0;
        errors     = 0;
        reads      = 0;
        read_due   = 1'b0;
    end

    // The host has priority, so each of its requests is granted at once.
    always @(posedge clock) begin
        if (host_req.valid && !host_gnt) begin
            $display("test %0d: a host request was not granted", test_idx);
            errors++;
        end
        if (rvalid) begin
            if (!armed || !read_due) begin
                $display("test %0d: read data came back with no host read pending", test_idx);
                errors++;
            end else begin
                reads++;
                if (rdata !== exp_data) begin
                    $display("ERROR test %0d: rdata got %h, expected %h",
                             test_idx, rdata, exp_data);
                    errors++;
                end
            end
        end else if (read_due) begin
            $display("ERROR test %0d: rvalid got %h, expected %h", test_idx, rvalid, 1'b1);
            errors++;
        end
        if (test_done) begin
            if (!halted) begin
                $display("test %0d: the core never reached the halted state", test_idx);
                errors++;
            end
            if (reads == 0) begin
                $display("test %0d: no read data came back to the host", test_idx);
                errors++;
            end
            if (errors == 0) begin
                $display("test %0d: ok, %0d reads checked", test_idx, reads);
                pass_count++;
            end else begin
                $display("test %0d: failed with %0d errors", test_idx, errors);
                fail_count++;
            end
            errors = 0;
            reads  = 0;
        end
        read_due <= host_req.valid && host_gnt && !host_req.write;
    end

endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
    import cpu_pkg::*;

    localparam int N_TESTS     = 11;
    localparam int PROG_LEN    = 12;
    localparam int TEST_CYCLES = 400;

    logic     clock;
    logic     rst_n;
    mem_req_t host_req;
    logic     host_gnt;
    logic     start;
    word_t    rdata;
    logic     rvalid;
    logic     halted;

    word_t    exp_data;
    logic     armed;
    logic     test_done;
    int       test_idx;
    int       pass_count;
    int       fail_count;
    integer   seed;

    // One row per program with its code, pre-written data word and result to read back.
    word_t     prog [N_TESTS][PROG_LEN];
    mem_addr_t res_addr [N_TESTS];
    word_t     exp_res [N_TESTS];
    logic      pre_en [N_TESTS];
    mem_addr_t pre_addr [N_TESTS];
    word_t     pre_data [N_TESTS];
    logic      contend [N_TESTS];

    tb_clock_gen i_clock_gen (
        .clock (clock),
        .rst_n (rst_n)
    );

    cpu_top i_cpu_top (
        .clock    (clock),
        .rst_n    (rst_n),
        .host_req (host_req),
        .host_gnt (host_gnt),
        .start    (start),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .halted   (halted)
    );

    tb_monitor i_monitor (
        .clock      (clock),
        .host_req   (host_req),
        .host_gnt   (host_gnt),
        .rvalid     (rvalid),
        .rdata      (rdata),
        .halted     (halted),
        .armed      (armed),
        .exp_data   (exp_data),
        .test_done  (test_done),
        .test_idx   (test_idx),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    function automatic word_t encode(opcode_e op, reg_idx_t rd, reg_idx_t ra,
                                     reg_idx_t rb, imm_t imm);
        return {op, rd, ra, rb, 3'b000, imm};
    endfunction

    function automatic word_t alu_ref(opcode_e op, word_t a, word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            default: return a ^ b;
        endcase
    endfunction

    // Sums n down to 1 into r2; r0 stays zero in every program.
    task automatic write_loop(int t, imm_t n, mem_addr_t addr);
        prog[t][0]  = encode(OP_LDI, 1, 0, 0, n);
        prog[t][1]  = encode(OP_LDI, 2, 0, 0, 16'h0);
        prog[t][2]  = encode(OP_LDI, 3, 0, 0, 16'h1);
        prog[t][3]  = encode(OP_CMPEQ, 4, 0, 0, 16'h0);
        prog[t][4]  = encode(OP_ADD, 2, 2, 1, 16'h0);
        prog[t][5]  = encode(OP_SUB, 1, 1, 3, 16'h0);
        prog[t][6]  = encode(OP_CMPEQ, 3, 1, 0, 16'h0);
        prog[t][7]  = encode(OP_BRF, 0, 3, 0, 16'd9);
        prog[t][8]  = encode(OP_BRF, 0, 4, 0, 16'd4);
        prog[t][9]  = encode(OP_LDI, 4, 0, 0, {8'h00, addr});
        prog[t][10] = encode(OP_ST, 0, 4, 2, 16'h0);
        prog[t][11] = encode(OP_HALT, 0, 0, 0, 16'h0);
        res_addr[t] = addr;
        exp_res[t]  = (n * (n + 1)) / 2;
    endtask

    task automatic write_branch(int t, opcode_e cmp_op, word_t expect_word);
        prog[t][0] = encode(OP_LDI, 1, 0, 0, 16'd5);
        prog[t][1] = encode(OP_LDI, 2, 0, 0, 16'd9);
        prog[t][2] = encode(cmp_op, 1, 1, 2, 16'h0);
        prog[t][3] = encode(OP_LDI, 4, 0, 0, 16'h00a0 + imm_t'(t));
        prog[t][4] = encode(OP_LDI, 3, 0, 0, 16'h1111);
        prog[t][5] = encode(OP_ST, 0, 4, 3, 16'h0);
        prog[t][6] = encode(OP_BRF, 0, 1, 0, 16'd9);
        prog[t][7] = encode(OP_LDI, 3, 0, 0, 16'hdead);
        prog[t][8] = encode(OP_ST, 0, 4, 3, 16'h0);
        res_addr[t] = 8'ha0 + mem_addr_t'(t);
        exp_res[t]  = expect_word;
    endtask

    task automatic build_table();
        opcode_e ops [5];
        word_t   a;
        word_t   b;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        for (int t = 0; t < N_TESTS; t++) begin
            for (int i = 0; i < PROG_LEN; i++) begin
                prog[t][i] = encode(OP_HALT, 0, 0, 0, 16'h0);
            end
            pre_en[t]  = 1'b0;
            contend[t] = 1'b0;
        end
        for (int t = 0; t < 5; t++) begin
            a = $random(seed);
            b = $random(seed);
            prog[t][0] = encode(OP_LDI, 1, 0, 0, a[15:0]);
            prog[t][1] = encode(OP_LDH, 1, 0, 0, a[31:16]);
            prog[t][2] = encode(OP_LDI, 2, 0, 0, b[15:0]);
            prog[t][3] = encode(OP_LDH, 2, 0, 0, b[31:16]);
            prog[t][4] = encode(ops[t], 3, 1, 2, 16'h0);
            prog[t][5] = encode(OP_LDI, 4, 0, 0, 16'h0090 + imm_t'(t));
            prog[t][6] = encode(OP_ST, 0, 4, 3, 16'h0);
            res_addr[t] = 8'h90 + mem_addr_t'(t);
            exp_res[t]  = alu_ref(ops[t], a, b);
        end
        // 5 < 9 sets the flag and skips the marker; 5 == 9 does not.
        write_branch(5, OP_CMPLT, 32'h0000_1111);
        write_branch(6, OP_CMPEQ, 32'h0000_dead);
        prog[7][0] = encode(OP_LDI, 1, 0, 0, 16'h00b0);
        prog[7][1] = encode(OP_LD, 2, 1, 0, 16'h0);
        prog[7][2] = encode(OP_LDI, 3, 0, 0, 16'h0100);
        prog[7][3] = encode(OP_ADD, 4, 2, 3, 16'h0);
        prog[7][4] = encode(OP_LDI, 5, 0, 0, 16'h00b1);
        prog[7][5] = encode(OP_ST, 0, 5, 4, 16'h0);
        pre_en[7]   = 1'b1;
        pre_addr[7] = 8'hb0;
        pre_data[7] = 32'h1234_5678;
        res_addr[7] = 8'hb1;
        exp_res[7]  = 32'h1234_5778;
        write_loop(8, 16'd10, 8'hc0);
        write_loop(9, 16'd12, 8'hc4);
        pre_en[9]   = 1'b1;
        contend[9]  = 1'b1;
        pre_addr[9] = 8'hd0;
        pre_data[9] = 32'hcafe_f00d;
        // The restarted program adds 0x77 to the loop sum left at 0xc0.
        prog[10][0] = encode(OP_LDI, 1, 0, 0, 16'h00c0);
        prog[10][1] = encode(OP_LD, 2, 1, 0, 16'h0);
        prog[10][2] = encode(OP_LDI, 3, 0, 0, 16'h0077);
        prog[10][3] = encode(OP_ADD, 4, 2, 3, 16'h0);
        prog[10][4] = encode(OP_LDI, 5, 0, 0, 16'h00e0);
        prog[10][5] = encode(OP_ST, 0, 5, 4, 16'h0);
        res_addr[10] = 8'he0;
        exp_res[10]  = 32'h0000_00ae;
    endtask

    task automatic host_access(logic wr, mem_addr_t addr, word_t data);
        int n;
        n = 0;
        @(posedge clock);
        host_req <= '{1'b1, wr, addr, data};
        do begin
            @(posedge clock);
            n++;
        end while (!host_gnt && n < 8);
        host_req <= '0;
        if (!wr) begin
            n = 0;
            do begin
                @(posedge clock);
                n++;
            end while (!rvalid && n < 4);
        end
    endtask

    task automatic run_test(int t);
        int cycles;
        test_idx <= t;
        armed    <= 1'b0;
        if (pre_en[t]) begin
            host_access(1'b1, pre_addr[t], pre_data[t]);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            host_access(1'b1, i[7:0], prog[t][i]);
        end
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        if (contend[t]) begin
            exp_data <= pre_data[t];
            armed    <= 1'b1;
        end
        @(posedge clock);
        cycles = 0;
        while (!halted && cycles < TEST_CYCLES) begin
            if (contend[t]) begin
                host_access(1'b0, pre_addr[t], '0);
                cycles += 3;
            end else begin
                @(posedge clock);
                cycles++;
            end
        end
        if (halted) begin
            exp_data <= exp_res[t];
            armed    <= 1'b1;
            host_access(1'b0, res_addr[t], '0);
        end
        test_done <= 1'b1;
        @(posedge clock);
        test_done <= 1'b0;
        armed     <= 1'b0;
    endtask

    initial begin
        repeat (N_TESTS * TEST_CYCLES) @(posedge clock);
        $display("watchdog expired before all tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        host_req  = '0;
        start     = 1'b0;
        exp_data  = '0;
        armed     = 1'b0;
        test_done = 1'b0;
        test_idx  = 0;
        seed      = 32'hb169c0e9;
        build_table();
        @(posedge rst_n);
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        @(posedge clock);
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == N_TESTS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
cpu_pkg.sv
alu.sv
reg_file.sv
cpu_core.sv
mem_arbiter.sv
data_mem.sv
cpu_top.sv
cpu_chk.sv
tb_clock_gen.sv
tb_monitor.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/bash
# Build and run with Verilator; the exit status follows the testbench result.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module tb_cpu -f filelist.f \
    && ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -qF '** PASS **' \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
